//--- hw/vuart_params.svh
// Virtual UART parameters
`ifndef VUART_PARAMS_SVH
`define VUART_PARAMS_SVH

// Bus widths
`define VUART_DATA_W 32
`define VUART_ADDR_W 32

// Register word indices, byte offsets 00h to 10h
`define VUART_RX_REG       3'd0
`define VUART_TX_REG       3'd1
`define VUART_STATUS_REG   3'd2
`define VUART_CONTROL_REG  3'd3
`define VUART_HOST_ACK_REG 3'd4

// Status and control bit positions
`define VUART_STS_RX_VALID 0
`define VUART_STS_RX_FULL  1
`define VUART_STS_TX_EMPTY 2
`define VUART_STS_TX_FULL  3
`define VUART_INT_EN       4
`define VUART_CTRL_RST     0

// Interrupt lines
`define VUART_CORE_INT 0
`define VUART_HOST_INT 1

// AXI response code
`define VUART_RESP_OKAY 2'b00

`endif

//--- hw/vuart_pkg.sv
// Virtual UART types
`include "vuart_params.svh"

package vuart_pkg;

    typedef logic [`VUART_DATA_W-1:0]   bus_data_t;
    typedef logic [`VUART_ADDR_W-1:0]   bus_addr_t;
    typedef logic [`VUART_DATA_W/8-1:0] bus_strb_t;
    typedef logic [1:0]                 axil_resp_t;

    // Word index taken from address bits 4 to 2
    typedef logic [2:0] reg_idx_t;

    typedef struct packed {
        bus_addr_t  addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        bus_data_t data;
        bus_strb_t strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_t resp;
    } axil_b_t;

    typedef struct packed {
        bus_addr_t  addr;
        logic [2:0] prot;
    } axil_ar_t;

    typedef struct packed {
        bus_data_t  data;
        axil_resp_t resp;
    } axil_r_t;

    // One register access as seen by the CSR block
    typedef struct packed {
        logic      write;
        reg_idx_t  idx;
        bus_data_t data;
        logic      strb;
    } reg_req_t;

endpackage

//--- hw/axil_slave_port.sv
// AXI-lite slave port
`timescale 1ns/1ps
`include "vuart_params.svh"

module axil_slave_port (
    input  logic                 clock_i,
    input  logic                 reset_ni,
    input  vuart_pkg::axil_aw_t  aw_i,
    input  logic                 aw_valid_i,
    output logic                 aw_ready_o,
    input  vuart_pkg::axil_w_t   w_i,
    input  logic                 w_valid_i,
    output logic                 w_ready_o,
    output vuart_pkg::axil_b_t   b_o,
    output logic                 b_valid_o,
    input  logic                 b_ready_i,
    input  vuart_pkg::axil_ar_t  ar_i,
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    output vuart_pkg::axil_r_t   r_o,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output vuart_pkg::reg_req_t  req_o,
    output logic                 req_valid_o,
    input  logic                 grant_i,
    input  vuart_pkg::bus_data_t rdata_i
);

    import vuart_pkg::*;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQUEST,
        PORT_RESPOND
    } port_state_e;

    port_state_e state_q;
    reg_req_t    req_q;
    bus_data_t   rdata_q;
    logic        write_hs;
    logic        read_hs;

    assign write_hs = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;
    assign read_hs  = ar_valid_i && ar_ready_o;

    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q     <= PORT_IDLE;
            aw_ready_o  <= 1'b0;
            w_ready_o   <= 1'b0;
            ar_ready_o  <= 1'b0;
            req_valid_o <= 1'b0;
            b_valid_o   <= 1'b0;
            r_valid_o   <= 1'b0;
        end else begin
            case (state_q)
                PORT_IDLE: begin
                    if (aw_ready_o || ar_ready_o) begin
                        // Ready pulse lasts a single cycle
                        aw_ready_o <= 1'b0;
                        w_ready_o  <= 1'b0;
                        ar_ready_o <= 1'b0;
                        if (write_hs || read_hs) begin
                            req_valid_o <= 1'b1;
                            state_q     <= PORT_REQUEST;
                        end
                    end else if (aw_valid_i && w_valid_i) begin
                        // Write wins over a read in the same cycle
                        aw_ready_o <= 1'b1;
                        w_ready_o  <= 1'b1;
                    end else if (ar_valid_i) begin
                        ar_ready_o <= 1'b1;
                    end
                end
                PORT_REQUEST: begin
                    if (grant_i) begin
                        req_valid_o <= 1'b0;
                        b_valid_o   <= req_q.write;
                        r_valid_o   <= !req_q.write;
                        state_q     <= PORT_RESPOND;
                    end
                end
                PORT_RESPOND: begin
                    if ((b_valid_o && b_ready_i) || (r_valid_o && r_ready_i)) begin
                        b_valid_o <= 1'b0;
                        r_valid_o <= 1'b0;
                        state_q   <= PORT_IDLE;
                    end
                end
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    // Request payload and captured read data
    always_ff @(posedge clock_i) begin
        if (write_hs) begin
            req_q.write <= 1'b1;
            req_q.idx   <= aw_i.addr[4:2];
            req_q.data  <= w_i.data;
            req_q.strb  <= w_i.strb[0];
        end else if (read_hs) begin
            req_q.write <= 1'b0;
            req_q.idx   <= ar_i.addr[4:2];
            req_q.data  <= '0;
            req_q.strb  <= 1'b0;
        end
        if (req_valid_o && grant_i && !req_q.write) begin
            rdata_q <= rdata_i;
        end
    end

    assign req_o    = req_q;
    assign b_o.resp = `VUART_RESP_OKAY;
    assign r_o.data = rdata_q;
    assign r_o.resp = `VUART_RESP_OKAY;

endmodule

//--- hw/reg_arbiter.sv
// Round-robin register arbiter
`timescale 1ns/1ps

module reg_arbiter (
    input  logic                clock_i,
    input  logic                reset_ni,
    input  vuart_pkg::reg_req_t core_req_i,
    input  logic                core_valid_i,
    input  vuart_pkg::reg_req_t host_req_i,
    input  logic                host_valid_i,
    output logic                core_grant_o,
    output logic                host_grant_o,
    output vuart_pkg::reg_req_t req_o,
    output logic                req_valid_o
);

    // Low favours the core, high favours the host
    logic prio_host_q;

    assign core_grant_o = core_valid_i && (!host_valid_i || !prio_host_q);
    assign host_grant_o = host_valid_i && (!core_valid_i || prio_host_q);

    assign req_valid_o = core_grant_o || host_grant_o;
    assign req_o       = host_grant_o ? host_req_i : core_req_i;

    // Hand priority to the other side after every grant
    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            prio_host_q <= 1'b0;
        end else if (core_grant_o) begin
            prio_host_q <= 1'b1;
        end else if (host_grant_o) begin
            prio_host_q <= 1'b0;
        end
    end

endmodule

//--- hw/vuart_csr.sv
// Virtual UART mailbox registers
`timescale 1ns/1ps
`include "vuart_params.svh"

module vuart_csr (
    input  logic                 clock_i,
    input  logic                 reset_ni,
    input  vuart_pkg::reg_req_t  req_i,
    input  logic                 req_valid_i,
    output vuart_pkg::bus_data_t rdata_o,
    output logic [1:0]           int_o,
    input  logic [1:0]           int_ack_i
);

    logic [7:0]             rx_data_q;
    logic [7:0]             tx_data_q;
    logic [`VUART_INT_EN:0] status_q;
    logic                   wr_en;
    logic                   rd_en;

    // Byte writes need the low strobe
    assign wr_en = req_valid_i && req_i.write && req_i.strb;
    assign rd_en = req_valid_i && !req_i.write;

    // Control and host ack are write only
    always_comb begin
        rdata_o = '0;
        case (req_i.idx)
            `VUART_RX_REG:     rdata_o[7:0] = rx_data_q;
            `VUART_TX_REG:     rdata_o[7:0] = tx_data_q;
            `VUART_STATUS_REG: rdata_o[`VUART_INT_EN:0] = status_q;
            default:           rdata_o = '0;
        endcase
    end

    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rx_data_q <= '0;
            tx_data_q <= '0;
            status_q  <= '0;
            int_o     <= '0;
        end else begin
            // Side-band acknowledges, a same-cycle set still wins
            if (int_ack_i[`VUART_CORE_INT]) begin
                int_o[`VUART_CORE_INT] <= 1'b0;
            end
            if (int_ack_i[`VUART_HOST_INT]) begin
                int_o[`VUART_HOST_INT] <= 1'b0;
            end

            if (wr_en) begin
                case (req_i.idx)
                    `VUART_RX_REG: begin
                        // Host has put a byte for the core
                        rx_data_q                     <= req_i.data[7:0];
                        status_q[`VUART_STS_RX_VALID] <= 1'b1;
                        status_q[`VUART_STS_RX_FULL]  <= 1'b1;
                        if (status_q[`VUART_INT_EN]) begin
                            int_o[`VUART_CORE_INT] <= 1'b1;
                        end
                    end
                    `VUART_TX_REG: begin
                        // Core has put a byte for the host
                        tx_data_q                     <= req_i.data[7:0];
                        status_q[`VUART_STS_TX_EMPTY] <= 1'b0;
                        status_q[`VUART_STS_TX_FULL]  <= 1'b1;
                        int_o[`VUART_HOST_INT]        <= 1'b1;
                    end
                    `VUART_CONTROL_REG: begin
                        if (req_i.data[`VUART_CTRL_RST]) begin
                            rx_data_q                     <= '0;
                            tx_data_q                     <= '0;
                            status_q[`VUART_STS_RX_VALID] <= 1'b0;
                            status_q[`VUART_STS_RX_FULL]  <= 1'b0;
                            status_q[`VUART_STS_TX_EMPTY] <= 1'b1;
                            status_q[`VUART_STS_TX_FULL]  <= 1'b0;
                        end
                        status_q[`VUART_INT_EN] <= req_i.data[`VUART_INT_EN];
                    end
                    `VUART_HOST_ACK_REG: begin
                        int_o[`VUART_HOST_INT] <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end

            // Reads drain the byte they return
            if (rd_en) begin
                case (req_i.idx)
                    `VUART_RX_REG: begin
                        status_q[`VUART_STS_RX_VALID] <= 1'b0;
                        status_q[`VUART_STS_RX_FULL]  <= 1'b0;
                        int_o[`VUART_CORE_INT]        <= 1'b0;
                    end
                    `VUART_TX_REG: begin
                        status_q[`VUART_STS_TX_EMPTY] <= 1'b1;
                        status_q[`VUART_STS_TX_FULL]  <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/vuart_top.sv
// Virtual UART top level
`timescale 1ns/1ps

module vuart_top (
    input  logic                clock_i,
    input  logic                reset_ni,
    input  vuart_pkg::axil_aw_t core_aw_i,
    input  logic                core_aw_valid_i,
    output logic                core_aw_ready_o,
    input  vuart_pkg::axil_w_t  core_w_i,
    input  logic                core_w_valid_i,
    output logic                core_w_ready_o,
    output vuart_pkg::axil_b_t  core_b_o,
    output logic                core_b_valid_o,
    input  logic                core_b_ready_i,
    input  vuart_pkg::axil_ar_t core_ar_i,
    input  logic                core_ar_valid_i,
    output logic                core_ar_ready_o,
    output vuart_pkg::axil_r_t  core_r_o,
    output logic                core_r_valid_o,
    input  logic                core_r_ready_i,
    input  vuart_pkg::axil_aw_t host_aw_i,
    input  logic                host_aw_valid_i,
    output logic                host_aw_ready_o,
    input  vuart_pkg::axil_w_t  host_w_i,
    input  logic                host_w_valid_i,
    output logic                host_w_ready_o,
    output vuart_pkg::axil_b_t  host_b_o,
    output logic                host_b_valid_o,
    input  logic                host_b_ready_i,
    input  vuart_pkg::axil_ar_t host_ar_i,
    input  logic                host_ar_valid_i,
    output logic                host_ar_ready_o,
    output vuart_pkg::axil_r_t  host_r_o,
    output logic                host_r_valid_o,
    input  logic                host_r_ready_i,
    output logic [1:0]          int_o,
    input  logic [1:0]          int_ack_i
);

    import vuart_pkg::*;

    reg_req_t  core_req;
    logic      core_req_valid;
    logic      core_grant;
    reg_req_t  host_req;
    logic      host_req_valid;
    logic      host_grant;
    reg_req_t  csr_req;
    logic      csr_req_valid;
    bus_data_t csr_rdata;

    // Soft core side
    axil_slave_port u_core_port (
        .clock_i(clock_i), .reset_ni(reset_ni),
        .aw_i(core_aw_i), .aw_valid_i(core_aw_valid_i), .aw_ready_o(core_aw_ready_o),
        .w_i(core_w_i), .w_valid_i(core_w_valid_i), .w_ready_o(core_w_ready_o),
        .b_o(core_b_o), .b_valid_o(core_b_valid_o), .b_ready_i(core_b_ready_i),
        .ar_i(core_ar_i), .ar_valid_i(core_ar_valid_i), .ar_ready_o(core_ar_ready_o),
        .r_o(core_r_o), .r_valid_o(core_r_valid_o), .r_ready_i(core_r_ready_i),
        .req_o(core_req), .req_valid_o(core_req_valid),
        .grant_i(core_grant), .rdata_i(csr_rdata)
    );

    // Host DMA side
    axil_slave_port u_host_port (
        .clock_i(clock_i), .reset_ni(reset_ni),
        .aw_i(host_aw_i), .aw_valid_i(host_aw_valid_i), .aw_ready_o(host_aw_ready_o),
        .w_i(host_w_i), .w_valid_i(host_w_valid_i), .w_ready_o(host_w_ready_o),
        .b_o(host_b_o), .b_valid_o(host_b_valid_o), .b_ready_i(host_b_ready_i),
        .ar_i(host_ar_i), .ar_valid_i(host_ar_valid_i), .ar_ready_o(host_ar_ready_o),
        .r_o(host_r_o), .r_valid_o(host_r_valid_o), .r_ready_i(host_r_ready_i),
        .req_o(host_req), .req_valid_o(host_req_valid),
        .grant_i(host_grant), .rdata_i(csr_rdata)
    );

    reg_arbiter u_arbiter (
        .clock_i(clock_i), .reset_ni(reset_ni),
        .core_req_i(core_req), .core_valid_i(core_req_valid),
        .host_req_i(host_req), .host_valid_i(host_req_valid),
        .core_grant_o(core_grant), .host_grant_o(host_grant),
        .req_o(csr_req), .req_valid_o(csr_req_valid)
    );

    vuart_csr u_csr (
        .clock_i(clock_i), .reset_ni(reset_ni),
        .req_i(csr_req), .req_valid_i(csr_req_valid), .rdata_o(csr_rdata),
        .int_o(int_o), .int_ack_i(int_ack_i)
    );

endmodule

//--- tests/vuart_checker.sv
// Virtual UART response checker
`timescale 1ns/1ps
`include "vuart_params.svh"

module vuart_checker (
    input  logic                 clock_i,
    input  logic                 reset_ni,
    input  vuart_pkg::axil_r_t   core_r_i,
    input  logic                 core_r_valid_i,
    input  logic                 core_r_ready_i,
    input  vuart_pkg::axil_r_t   host_r_i,
    input  logic                 host_r_valid_i,
    input  logic                 host_r_ready_i,
    input  vuart_pkg::axil_b_t   core_b_i,
    input  logic                 core_b_valid_i,
    input  logic                 core_b_ready_i,
    input  vuart_pkg::axil_b_t   host_b_i,
    input  logic                 host_b_valid_i,
    input  logic                 host_b_ready_i,
    input  vuart_pkg::bus_data_t core_exp_i,
    input  vuart_pkg::bus_data_t host_exp_i,
    input  logic [1:0]           int_i,
    input  logic [1:0]           int_exp_i,
    input  logic                 int_check_i,
    input  logic                 test_end_i,
    input  int                   test_id_i,
    output int                   checks_o,
    output int                   errors_o
);

    import vuart_pkg::*;

    int test_errors;

    task automatic compare(input string name, input bus_data_t expected, input bus_data_t got);
        checks_o++;
        if (expected !== got) begin
            errors_o++;
            test_errors++;
            $display("error %s expected %h got %h", name, expected, got);
        end
    endtask

    // Stimulus moves on the falling edge, so the rising edge sees it settled
    always @(posedge clock_i) begin
        if (!reset_ni) begin
            checks_o    = 0;
            errors_o    = 0;
            test_errors = 0;
        end else begin
            if (core_r_valid_i && core_r_ready_i) begin
                compare("core_r_o.data", core_exp_i, core_r_i.data);
                compare("core_r_o.resp", {30'd0, `VUART_RESP_OKAY}, {30'd0, core_r_i.resp});
            end
            if (host_r_valid_i && host_r_ready_i) begin
                compare("host_r_o.data", host_exp_i, host_r_i.data);
                compare("host_r_o.resp", {30'd0, `VUART_RESP_OKAY}, {30'd0, host_r_i.resp});
            end
            if (core_b_valid_i && core_b_ready_i) begin
                compare("core_b_o.resp", {30'd0, `VUART_RESP_OKAY}, {30'd0, core_b_i.resp});
            end
            if (host_b_valid_i && host_b_ready_i) begin
                compare("host_b_o.resp", {30'd0, `VUART_RESP_OKAY}, {30'd0, host_b_i.resp});
            end
            if (int_check_i) begin
                compare("int_o", {30'd0, int_exp_i}, {30'd0, int_i});
            end
            if (test_end_i) begin
                $display("test %0d done with %0d errors", test_id_i, test_errors);
                test_errors = 0;
            end
        end
    end

endmodule

//--- tests/tb_vuart.sv
// Virtual UART testbench
`timescale 1ns/1ps
`include "vuart_params.svh"

module tb_vuart;

    import vuart_pkg::*;

    localparam int   WAIT_LIMIT = 200;
    localparam logic CORE       = 1'b0;
    localparam logic HOST       = 1'b1;

    logic       clock;
    logic       reset_n;
    logic [1:0] irq;
    logic [1:0] int_ack;

    // Index 0 is the core port, index 1 the host port
    axil_aw_t  aw [2];
    logic      aw_valid [2];
    logic      aw_ready [2];
    axil_w_t   w [2];
    logic      w_valid [2];
    logic      w_ready [2];
    axil_b_t   b [2];
    logic      b_valid [2];
    logic      b_ready [2];
    axil_ar_t  ar [2];
    logic      ar_valid [2];
    logic      ar_ready [2];
    axil_r_t   r [2];
    logic      r_valid [2];
    logic      r_ready [2];
    bus_data_t exp_rdata [2];

    // Reference model state
    logic [7:0]             m_rx;
    logic [7:0]             m_tx;
    logic [`VUART_INT_EN:0] m_status;
    logic [1:0]             m_int;

    logic [1:0]  int_exp;
    logic        int_check;
    logic        test_end;
    int          test_id;
    int          checks;
    int          errors;
    logic [15:0] lfsr;
    logic [7:0]  core_byte;
    logic [7:0]  host_byte;
    logic [7:0]  core_hold;
    logic [7:0]  host_hold;
    int          k;

    vuart_top u_vuart_top (
        .clock_i(clock), .reset_ni(reset_n),
        .core_aw_i(aw[0]), .core_aw_valid_i(aw_valid[0]), .core_aw_ready_o(aw_ready[0]),
        .core_w_i(w[0]), .core_w_valid_i(w_valid[0]), .core_w_ready_o(w_ready[0]),
        .core_b_o(b[0]), .core_b_valid_o(b_valid[0]), .core_b_ready_i(b_ready[0]),
        .core_ar_i(ar[0]), .core_ar_valid_i(ar_valid[0]), .core_ar_ready_o(ar_ready[0]),
        .core_r_o(r[0]), .core_r_valid_o(r_valid[0]), .core_r_ready_i(r_ready[0]),
        .host_aw_i(aw[1]), .host_aw_valid_i(aw_valid[1]), .host_aw_ready_o(aw_ready[1]),
        .host_w_i(w[1]), .host_w_valid_i(w_valid[1]), .host_w_ready_o(w_ready[1]),
        .host_b_o(b[1]), .host_b_valid_o(b_valid[1]), .host_b_ready_i(b_ready[1]),
        .host_ar_i(ar[1]), .host_ar_valid_i(ar_valid[1]), .host_ar_ready_o(ar_ready[1]),
        .host_r_o(r[1]), .host_r_valid_o(r_valid[1]), .host_r_ready_i(r_ready[1]),
        .int_o(irq), .int_ack_i(int_ack)
    );

    vuart_checker u_checker (
        .clock_i(clock), .reset_ni(reset_n),
        .core_r_i(r[0]), .core_r_valid_i(r_valid[0]), .core_r_ready_i(r_ready[0]),
        .host_r_i(r[1]), .host_r_valid_i(r_valid[1]), .host_r_ready_i(r_ready[1]),
        .core_b_i(b[0]), .core_b_valid_i(b_valid[0]), .core_b_ready_i(b_ready[0]),
        .host_b_i(b[1]), .host_b_valid_i(b_valid[1]), .host_b_ready_i(b_ready[1]),
        .core_exp_i(exp_rdata[0]), .host_exp_i(exp_rdata[1]),
        .int_i(irq), .int_exp_i(int_exp), .int_check_i(int_check),
        .test_end_i(test_end), .test_id_i(test_id),
        .checks_o(checks), .errors_o(errors)
    );

    always #5 clock = ~clock;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        logic       fb;
        int         i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    // Mailbox behaviour for one access, returns the expected read data
    function automatic bus_data_t vuart_model(input logic write, input reg_idx_t idx,
                                              input bus_data_t data, input logic strb);
        bus_data_t rd;
        rd = '0;
        if (write && strb) begin
            case (idx)
                `VUART_RX_REG: begin
                    m_rx        = data[7:0];
                    m_status[1:0] = 2'b11;
                    if (m_status[`VUART_INT_EN]) begin
                        m_int[`VUART_CORE_INT] = 1'b1;
                    end
                end
                `VUART_TX_REG: begin
                    m_tx                   = data[7:0];
                    m_status[3:2]          = 2'b10;
                    m_int[`VUART_HOST_INT] = 1'b1;
                end
                `VUART_CONTROL_REG: begin
                    if (data[`VUART_CTRL_RST]) begin
                        m_rx          = '0;
                        m_tx          = '0;
                        m_status[3:0] = 4'b0100;
                    end
                    m_status[`VUART_INT_EN] = data[`VUART_INT_EN];
                end
                `VUART_HOST_ACK_REG: m_int[`VUART_HOST_INT] = 1'b0;
                default: ;
            endcase
        end else if (!write) begin
            case (idx)
                `VUART_RX_REG: begin
                    rd                     = {24'd0, m_rx};
                    m_status[1:0]          = 2'b00;
                    m_int[`VUART_CORE_INT] = 1'b0;
                end
                `VUART_TX_REG: begin
                    rd            = {24'd0, m_tx};
                    m_status[3:2] = 2'b01;
                end
                `VUART_STATUS_REG: rd = {27'd0, m_status};
                default: rd = '0;
            endcase
        end
        return rd;
    endfunction

    task automatic abort_on_timeout(input string what, input logic p);
        $display("timeout waiting for %s on the %s port", what, (p == HOST) ? "host" : "core");
        $display("Regression failed");
        $finish;
    endtask

    task automatic axil_write(input logic p, input reg_idx_t idx, input bus_data_t data,
                              input logic [3:0] strb, input logic [7:0] hold);
        int n;
        @(negedge clock);
        void'(vuart_model(1'b1, idx, data, strb[0]));
        aw[p].addr  = {27'd0, idx, 2'b00};
        aw[p].prot  = 3'd0;
        w[p].data   = data;
        w[p].strb   = strb;
        aw_valid[p] = 1'b1;
        w_valid[p]  = 1'b1;
        n = 0;
        while (!(aw_ready[p] && w_ready[p])) begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("write address and data ready", p);
        end
        @(negedge clock);
        aw_valid[p] = 1'b0;
        w_valid[p]  = 1'b0;
        // Back-pressure on the write response
        repeat (hold) @(negedge clock);
        b_ready[p] = 1'b1;
        n = 0;
        while (!b_valid[p]) begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("write response", p);
        end
        @(negedge clock);
        b_ready[p] = 1'b0;
    endtask

    task automatic axil_read(input logic p, input reg_idx_t idx);
        int n;
        @(negedge clock);
        exp_rdata[p] = vuart_model(1'b0, idx, '0, 1'b0);
        ar[p].addr   = {27'd0, idx, 2'b00};
        ar[p].prot   = 3'd0;
        ar_valid[p]  = 1'b1;
        n = 0;
        while (!ar_ready[p]) begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("read address ready", p);
        end
        @(negedge clock);
        ar_valid[p] = 1'b0;
        r_ready[p]  = 1'b1;
        n = 0;
        while (!r_valid[p]) begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("read response", p);
        end
        @(negedge clock);
        r_ready[p] = 1'b0;
    endtask

    task automatic check_int();
        @(negedge clock);
        int_exp   = m_int;
        int_check = 1'b1;
        @(negedge clock);
        int_check = 1'b0;
    endtask

    task automatic pulse_int_ack(input logic line);
        @(negedge clock);
        int_ack[line] = 1'b1;
        m_int[line]   = 1'b0;
        @(negedge clock);
        int_ack = 2'b00;
    endtask

    task automatic finish_test();
        @(negedge clock);
        test_end = 1'b1;
        @(negedge clock);
        test_end = 1'b0;
        test_id++;
    endtask

    initial begin
        clock     = 1'b0;
        reset_n   = 1'b0;
        int_ack   = 2'b00;
        aw        = '{default: '0};
        aw_valid  = '{default: 1'b0};
        w         = '{default: '0};
        w_valid   = '{default: 1'b0};
        b_ready   = '{default: 1'b0};
        ar        = '{default: '0};
        ar_valid  = '{default: 1'b0};
        r_ready   = '{default: 1'b0};
        exp_rdata = '{default: '0};
        m_rx      = '0;
        m_tx      = '0;
        m_status  = '0;
        m_int     = '0;
        int_exp   = '0;
        int_check = 1'b0;
        test_end  = 1'b0;
        test_id   = 1;
        lfsr      = 16'd7;
        repeat (10) @(negedge clock);
        reset_n = 1'b1;

        // Core to host through TX
        axil_write(CORE, `VUART_TX_REG, {24'd0, rand_bits(8)}, 4'hf, 8'd0);
        check_int();
        axil_read(HOST, `VUART_STATUS_REG);
        axil_read(HOST, `VUART_TX_REG);
        axil_read(HOST, `VUART_STATUS_REG);
        axil_write(HOST, `VUART_HOST_ACK_REG, '0, 4'hf, 8'd0);
        check_int();
        finish_test();

        // Host to core through RX with the interrupt enabled
        axil_write(CORE, `VUART_CONTROL_REG, 32'h10, 4'hf, 8'd0);
        axil_write(HOST, `VUART_RX_REG, {24'd0, rand_bits(8)}, 4'hf, 8'd0);
        check_int();
        axil_read(CORE, `VUART_STATUS_REG);
        axil_read(CORE, `VUART_RX_REG);
        axil_read(CORE, `VUART_STATUS_REG);
        check_int();
        finish_test();

        // Control reset of both bytes, then side-band acknowledges
        axil_write(CORE, `VUART_TX_REG, {24'd0, rand_bits(8)}, 4'hf, 8'd0);
        axil_write(HOST, `VUART_RX_REG, {24'd0, rand_bits(8)}, 4'hf, 8'd0);
        axil_write(CORE, `VUART_CONTROL_REG, 32'h11, 4'hf, 8'd0);
        check_int();
        axil_read(HOST, `VUART_STATUS_REG);
        axil_read(HOST, `VUART_TX_REG);
        pulse_int_ack(1'(`VUART_CORE_INT));
        check_int();
        pulse_int_ack(1'(`VUART_HOST_INT));
        check_int();
        axil_read(CORE, `VUART_RX_REG);
        finish_test();

        // Unused indices and a cleared byte strobe
        for (k = 5; k < 8; k++) begin
            axil_write(HOST, 3'(k), 32'hffff_ffff, 4'hf, 8'd0);
            axil_read(CORE, 3'(k));
        end
        axil_write(CORE, `VUART_TX_REG, {24'd0, rand_bits(8)}, 4'he, 8'd0);
        axil_write(HOST, `VUART_RX_REG, {24'd0, rand_bits(8)}, 4'he, 8'd0);
        check_int();
        axil_read(HOST, `VUART_STATUS_REG);
        axil_read(HOST, `VUART_TX_REG);
        axil_read(CORE, `VUART_RX_REG);
        finish_test();

        // Both ports write in the same cycle
        for (k = 0; k < 20; k++) begin
            core_byte = rand_bits(8);
            host_byte = rand_bits(8);
            core_hold = rand_bits(3);
            host_hold = rand_bits(3);
            fork
                axil_write(CORE, `VUART_TX_REG, {24'd0, core_byte}, 4'hf, core_hold);
                axil_write(HOST, `VUART_RX_REG, {24'd0, host_byte}, 4'hf, host_hold);
            join
        end
        axil_read(CORE, `VUART_STATUS_REG);
        axil_read(HOST, `VUART_TX_REG);
        axil_read(CORE, `VUART_RX_REG);
        check_int();
        finish_test();

        repeat (2) @(negedge clock);
        $display("%0d tests, %0d checks, %0d errors", test_id - 1, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hw
hw/vuart_pkg.sv
hw/axil_slave_port.sv
hw/reg_arbiter.sv
hw/vuart_csr.sv
hw/vuart_top.sv
tests/vuart_checker.sv
tests/tb_vuart.sv

//--- run.sh
#!/usr/bin/env bash
# Build the virtual UART testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f list.f --top-module tb_vuart -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_output=$(./obj_dir/Vtb_vuart 2>&1); then
    echo "$sim_output"
    echo "Simulation exited with a failing status"
    exit 1
fi
echo "$sim_output"

if grep -qx "Regression passed" <<< "$sim_output"; then
    exit 0
fi
exit 1
